// ==== logic/tx_bd_pkg.sv ====
package tx_bd_pkg;

    localparam int SN_W     = 9;
    localparam int BD_W     = 288;
    localparam int CMD_W    = 256;
    localparam int OUT_W    = 512;
    localparam int LEN_W    = 32;
    localparam int RD_LEN_W = 13;
    localparam int ADDR_W   = 64;
    localparam int VE_W     = 48;
    localparam int ACC_W    = 8;
    localparam int TID_W    = 8;
    localparam int OPC_W    = 2;

    // ----------------------------------------
    // descriptor fields after lane swap
    localparam int IN_TID_LSB = 226;
    localparam int IN_OPC_LSB = 224;
    localparam int IN_ACC_LSB = 208;
    localparam int IN_VE_LSB  = 160;
    localparam int IN_LEN_LSB = 128;
    localparam int IN_DST_LSB = 64;
    localparam int IN_SRC_LSB = 0;

    // read command fields before lane swap
    localparam int CMD_SOD_BIT  = 254;
    localparam int CMD_EOD_BIT  = 253;
    localparam int CMD_LEN_LSB  = 235;
    localparam int CMD_OPC_LSB  = 233;
    localparam int CMD_SN_LSB   = 224;
    localparam int CMD_ACC_LSB  = 208;
    localparam int CMD_VE_LSB   = 160;
    localparam int CMD_LEN2_LSB = 128;
    localparam int CMD_SRC_LSB  = 0;

    // output descriptor fields before byte reverse
    localparam int OUT_SRC_LSB = 0;
    localparam int OUT_DST_LSB = 64;
    localparam int OUT_VE_LSB  = 128;
    localparam int OUT_OPC_LSB = 224;
    localparam int OUT_TID_LSB = 226;
    localparam int OUT_LEN_LSB = 256;

    typedef struct packed {
        logic [TID_W-1:0]  tid;
        logic [OPC_W-1:0]  opcode;
        logic [LEN_W-1:0]  len;
        logic [VE_W-1:0]   ve;
        logic [ADDR_W-1:0] dst;
        logic [ADDR_W-1:0] src;
    } bd_rec_t;

    // byte order flipped inside each 128-bit lane of the low 256 bits
    function automatic logic [BD_W-1:0] lane_swap(input logic [BD_W-1:0] d);
        logic [BD_W-1:0] r;
        r = d;
        for (int l = 0; l < 2; l++) begin
            for (int b = 0; b < 16; b++) begin
                r[l*128 + b*8 +: 8] = d[l*128 + (15-b)*8 +: 8];
            end
        end
        return r;
    endfunction

    function automatic logic [OUT_W-1:0] byte_reverse(input logic [OUT_W-1:0] d);
        logic [OUT_W-1:0] r;
        r = '0;
        for (int b = 0; b < OUT_W/8; b++) begin
            r[b*8 +: 8] = d[(OUT_W/8-1-b)*8 +: 8];
        end
        return r;
    endfunction

endpackage

// ==== logic/bd_ram.sv ====
`timescale 1ns/1ps

module bd_ram (
    input  logic                        clk_sys,
    input  logic                        ram_wr,
    input  logic [tx_bd_pkg::SN_W-1:0]  ram_waddr,
    input  tx_bd_pkg::bd_rec_t          ram_wrec,
    input  logic [tx_bd_pkg::SN_W-1:0]  ram_raddr,
    output tx_bd_pkg::bd_rec_t          ram_rrec
);
    import tx_bd_pkg::*;

    bd_rec_t mem [1 << SN_W];

    // one record per serial number
    always_ff @(posedge clk_sys) begin
        if (ram_wr) begin
            mem[ram_waddr] <= ram_wrec;
        end
        ram_rrec <= mem[ram_raddr];
    end

endmodule

// ==== logic/rsp_fifo.sv ====
`timescale 1ns/1ps

module rsp_fifo #(
    parameter int RSP_AFULL_THD = 450
) (
    input  logic                        clk_sys,
    input  logic                        rst,
    input  logic                        rsp_wr,
    input  logic [tx_bd_pkg::SN_W-1:0]  rsp_sn,
    input  logic                        rsp_rd,
    output logic [tx_bd_pkg::SN_W-1:0]  rsp_head,
    output logic                        rsp_empty,
    output logic                        rsp_afull
);
    import tx_bd_pkg::*;

    logic [SN_W-1:0] mem [1 << SN_W];
    logic [SN_W-1:0] wr_ptr;
    logic [SN_W-1:0] rd_ptr;
    logic [SN_W:0]   count;

    always_ff @(posedge clk_sys) begin
        if (rsp_wr) begin
            mem[wr_ptr] <= rsp_sn;
        end
    end

    always_ff @(posedge clk_sys or posedge rst) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (rsp_wr) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (rsp_rd) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            if (rsp_wr && !rsp_rd) begin
                count <= count + 1'b1;
            end else if (!rsp_wr && rsp_rd) begin
                count <= count - 1'b1;
            end
        end
    end

    // show-ahead head
    assign rsp_head  = mem[rd_ptr];
    assign rsp_empty = (count == '0);
    assign rsp_afull = (count >= RSP_AFULL_THD);

endmodule

// ==== logic/bd_fetch.sv ====
`timescale 1ns/1ps

module bd_fetch #(
    parameter int BD_INFLIGHT_MAX = 450
) (
    input  logic                            clk_sys,
    input  logic                            rst,
    input  logic [tx_bd_pkg::BD_W-1:0]      bd_rdata,
    input  logic                            bd_empty,
    input  logic                            split_busy,
    input  logic                            rsp_rd,
    input  logic                            rsp_afull,
    output logic                            bd_rd,
    output logic                            ram_wr,
    output logic [tx_bd_pkg::SN_W-1:0]      ram_waddr,
    output tx_bd_pkg::bd_rec_t              ram_wrec,
    output logic                            start,
    output logic [tx_bd_pkg::LEN_W-1:0]     start_len,
    output logic [tx_bd_pkg::ADDR_W-1:0]    start_src,
    output logic [tx_bd_pkg::OPC_W-1:0]     start_opcode,
    output logic [tx_bd_pkg::ACC_W-1:0]     start_acc,
    output logic [tx_bd_pkg::VE_W-1:0]      start_ve,
    output logic [tx_bd_pkg::SN_W-1:0]      start_sn
);
    import tx_bd_pkg::*;

    logic [BD_W-1:0] bd_swap;
    logic [SN_W-1:0] sn_cnt;
    logic [SN_W:0]   inflight;
    logic            pop_ok;

    assign bd_swap = lane_swap(bd_rdata);

    assign pop_ok = !bd_empty && !rsp_afull && !split_busy && !bd_rd &&
                    (inflight < BD_INFLIGHT_MAX);

    // ----------------------------------------
    // pop strobe, serial number, in-flight count
    always_ff @(posedge clk_sys or posedge rst) begin
        if (rst) begin
            bd_rd    <= 1'b0;
            ram_wr   <= 1'b0;
            sn_cnt   <= '0;
            inflight <= '0;
        end else begin
            bd_rd  <= pop_ok;
            ram_wr <= bd_rd;
            if (bd_rd) begin
                sn_cnt <= sn_cnt + 1'b1;
            end
            if (bd_rd && !rsp_rd) begin
                inflight <= inflight + 1'b1;
            end else if (!bd_rd && rsp_rd) begin
                inflight <= inflight - 1'b1;
            end
        end
    end

    // field latch from the head word
    always_ff @(posedge clk_sys) begin
        if (bd_rd) begin
            ram_waddr       <= sn_cnt;
            ram_wrec.tid    <= bd_swap[IN_TID_LSB +: TID_W];
            ram_wrec.opcode <= bd_swap[IN_OPC_LSB +: OPC_W];
            ram_wrec.len    <= bd_swap[IN_LEN_LSB +: LEN_W];
            ram_wrec.ve     <= bd_swap[IN_VE_LSB +: VE_W];
            ram_wrec.dst    <= bd_swap[IN_DST_LSB +: ADDR_W];
            ram_wrec.src    <= bd_swap[IN_SRC_LSB +: ADDR_W];
            start_acc       <= bd_swap[IN_ACC_LSB +: ACC_W];
        end
    end

    // splitter start shares the record write cycle
    assign start        = ram_wr;
    assign start_sn     = ram_waddr;
    assign start_len    = ram_wrec.len;
    assign start_src    = ram_wrec.src;
    assign start_opcode = ram_wrec.opcode;
    assign start_ve     = ram_wrec.ve;

endmodule

// ==== logic/rd_cmd_split.sv ====
`timescale 1ns/1ps

module rd_cmd_split #(
    parameter int CHUNK_SHIFT = 12
) (
    input  logic                            clk_sys,
    input  logic                            rst,
    input  logic                            start,
    input  logic [tx_bd_pkg::LEN_W-1:0]     start_len,
    input  logic [tx_bd_pkg::ADDR_W-1:0]    start_src,
    input  logic [tx_bd_pkg::OPC_W-1:0]     start_opcode,
    input  logic [tx_bd_pkg::ACC_W-1:0]     start_acc,
    input  logic [tx_bd_pkg::VE_W-1:0]      start_ve,
    input  logic [tx_bd_pkg::SN_W-1:0]      start_sn,
    input  logic                            cmd_ff,
    output logic                            split_busy,
    output logic                            cmd_wr,
    output logic [tx_bd_pkg::CMD_W-1:0]     cmd_wdata
);
    import tx_bd_pkg::*;

    localparam logic [RD_LEN_W-1:0] CHUNK_LEN = RD_LEN_W'(1) << CHUNK_SHIFT;

    logic                         busy;
    logic                         first;
    logic [LEN_W-CHUNK_SHIFT-1:0] left_full;
    logic [CHUNK_SHIFT-1:0]       left_rem;
    logic                         issue;
    logic                         last;
    logic                         cur_sod;
    logic                         cur_eod;
    logic [RD_LEN_W-1:0]          cur_len;
    logic [ADDR_W-1:0]            cur_addr;
    logic [ADDR_W-1:0]            next_addr;
    logic [OPC_W-1:0]             opcode;
    logic [ACC_W-1:0]             acc;
    logic [VE_W-1:0]              ve;
    logic [SN_W-1:0]              sn;
    logic [CMD_W-1:0]             cmd_raw;

    // busy already in the start cycle so no second pop slips in
    assign split_busy = busy || start;

    assign issue = busy && !cmd_wr && !cmd_ff;
    assign last  = (left_full == '0) || ((left_full == 1) && (left_rem == '0));

    // ----------------------------------------
    // chunk bookkeeping
    always_ff @(posedge clk_sys or posedge rst) begin
        if (rst) begin
            busy      <= 1'b0;
            first     <= 1'b0;
            left_full <= '0;
            left_rem  <= '0;
            cmd_wr    <= 1'b0;
            cur_sod   <= 1'b0;
            cur_eod   <= 1'b0;
        end else begin
            cmd_wr <= issue;
            if (start) begin
                busy      <= 1'b1;
                first     <= 1'b1;
                left_full <= start_len[LEN_W-1:CHUNK_SHIFT];
                left_rem  <= start_len[CHUNK_SHIFT-1:0];
            end else if (issue) begin
                cur_sod <= first;
                cur_eod <= last;
                first   <= 1'b0;
                if (left_full != '0) begin
                    left_full <= left_full - 1'b1;
                end
            end else if (cmd_wr && cur_eod) begin
                busy <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk_sys) begin
        if (start) begin
            next_addr <= start_src;
            opcode    <= start_opcode;
            acc       <= start_acc;
            ve        <= start_ve;
            sn        <= start_sn;
        end else if (issue) begin
            cur_addr  <= next_addr;
            cur_len   <= (left_full != '0) ? CHUNK_LEN : RD_LEN_W'(left_rem);
            next_addr <= next_addr + ADDR_W'(CHUNK_LEN);
        end
    end

    // ----------------------------------------
    // command word
    always_comb begin
        cmd_raw                              = '0;
        cmd_raw[CMD_SOD_BIT]                 = cur_sod;
        cmd_raw[CMD_EOD_BIT]                 = cur_eod;
        cmd_raw[CMD_LEN_LSB +: RD_LEN_W]     = cur_len;
        cmd_raw[CMD_OPC_LSB +: OPC_W]        = opcode;
        cmd_raw[CMD_SN_LSB +: SN_W]          = sn;
        cmd_raw[CMD_ACC_LSB +: ACC_W]        = acc;
        cmd_raw[CMD_VE_LSB +: VE_W]          = ve;
        cmd_raw[CMD_LEN2_LSB +: RD_LEN_W]    = cur_len;
        cmd_raw[CMD_SRC_LSB +: ADDR_W]       = cur_addr;
    end

    assign cmd_wdata = CMD_W'(lane_swap(BD_W'(cmd_raw)));

endmodule

// ==== logic/bd_dispatch.sv ====
`timescale 1ns/1ps

module bd_dispatch #(
    parameter int RSP_AFULL_THD = 450
) (
    input  logic                        clk_sys,
    input  logic                        rst,
    input  logic                        rsp_wr,
    input  logic [tx_bd_pkg::SN_W-1:0]  rsp_sn,
    input  logic                        kernel_afull,
    input  logic                        mmu_afull,
    input  tx_bd_pkg::bd_rec_t          ram_rrec,
    output logic                        rsp_rd,
    output logic                        rsp_afull,
    output logic [tx_bd_pkg::SN_W-1:0]  ram_raddr,
    output logic                        kernel_bd_wen,
    output logic                        mmu_bd_wen,
    output logic [tx_bd_pkg::OUT_W-1:0] bd_wdata
);
    import tx_bd_pkg::*;

    logic             rsp_empty;
    logic             rd_d1;
    logic [OUT_W-1:0] out_raw;

    rsp_fifo #(
        .RSP_AFULL_THD (RSP_AFULL_THD)
    ) u_rsp_fifo (
        .clk_sys   (clk_sys),
        .rst       (rst),
        .rsp_wr    (rsp_wr),
        .rsp_sn    (rsp_sn),
        .rsp_rd    (rsp_rd),
        .rsp_head  (ram_raddr),
        .rsp_empty (rsp_empty),
        .rsp_afull (rsp_afull)
    );

    always_comb begin
        out_raw                          = '0;
        out_raw[OUT_SRC_LSB +: ADDR_W]   = ram_rrec.src;
        out_raw[OUT_DST_LSB +: ADDR_W]   = ram_rrec.dst;
        out_raw[OUT_VE_LSB +: VE_W]      = ram_rrec.ve;
        out_raw[OUT_OPC_LSB +: OPC_W]    = ram_rrec.opcode;
        out_raw[OUT_TID_LSB +: TID_W]    = ram_rrec.tid;
        out_raw[OUT_LEN_LSB +: LEN_W]    = ram_rrec.len;
    end

    // ----------------------------------------
    // pop, ram read, then route by opcode
    always_ff @(posedge clk_sys or posedge rst) begin
        if (rst) begin
            rsp_rd        <= 1'b0;
            rd_d1         <= 1'b0;
            kernel_bd_wen <= 1'b0;
            mmu_bd_wen    <= 1'b0;
        end else begin
            rsp_rd <= !rsp_empty && !kernel_afull && !mmu_afull && !rsp_rd;
            rd_d1  <= rsp_rd;
            // 0 and 3 are process ops, 1 and 2 go to the rx mmu
            kernel_bd_wen <= rd_d1 && (ram_rrec.opcode[1] == ram_rrec.opcode[0]);
            mmu_bd_wen    <= rd_d1 && (ram_rrec.opcode[1] != ram_rrec.opcode[0]);
        end
    end

    always_ff @(posedge clk_sys) begin
        if (rd_d1) begin
            bd_wdata <= byte_reverse(out_raw);
        end
    end

endmodule

// ==== logic/tx_bd.sv ====
`timescale 1ns/1ps

module tx_bd #(
    parameter int BD_INFLIGHT_MAX = 450,
    parameter int RSP_AFULL_THD   = 450,
    parameter int CHUNK_SHIFT     = 12
) (
    input  logic                        clk_sys,
    input  logic                        rst,
    input  logic [tx_bd_pkg::BD_W-1:0]  bd_rdata,
    input  logic                        bd_empty,
    output logic                        bd_rd,
    input  logic                        cmd_ff,
    output logic                        cmd_wr,
    output logic [tx_bd_pkg::CMD_W-1:0] cmd_wdata,
    input  logic                        rsp_wr,
    input  logic [tx_bd_pkg::SN_W-1:0]  rsp_sn,
    input  logic                        kernel_afull,
    input  logic                        mmu_afull,
    output logic                        kernel_bd_wen,
    output logic                        mmu_bd_wen,
    output logic [tx_bd_pkg::OUT_W-1:0] bd_wdata
);
    import tx_bd_pkg::*;

    logic              ram_wr;
    logic [SN_W-1:0]   ram_waddr;
    bd_rec_t           ram_wrec;
    logic [SN_W-1:0]   ram_raddr;
    bd_rec_t           ram_rrec;
    logic              start;
    logic [LEN_W-1:0]  start_len;
    logic [ADDR_W-1:0] start_src;
    logic [OPC_W-1:0]  start_opcode;
    logic [ACC_W-1:0]  start_acc;
    logic [VE_W-1:0]   start_ve;
    logic [SN_W-1:0]   start_sn;
    logic              split_busy;
    logic              rsp_rd;
    logic              rsp_afull;

    // ----------------------------------------
    // input side
    bd_fetch #(
        .BD_INFLIGHT_MAX (BD_INFLIGHT_MAX)
    ) u_bd_fetch (
        .clk_sys      (clk_sys),
        .rst          (rst),
        .bd_rdata     (bd_rdata),
        .bd_empty     (bd_empty),
        .split_busy   (split_busy),
        .rsp_rd       (rsp_rd),
        .rsp_afull    (rsp_afull),
        .bd_rd        (bd_rd),
        .ram_wr       (ram_wr),
        .ram_waddr    (ram_waddr),
        .ram_wrec     (ram_wrec),
        .start        (start),
        .start_len    (start_len),
        .start_src    (start_src),
        .start_opcode (start_opcode),
        .start_acc    (start_acc),
        .start_ve     (start_ve),
        .start_sn     (start_sn)
    );

    rd_cmd_split #(
        .CHUNK_SHIFT (CHUNK_SHIFT)
    ) u_rd_cmd_split (
        .clk_sys      (clk_sys),
        .rst          (rst),
        .start        (start),
        .start_len    (start_len),
        .start_src    (start_src),
        .start_opcode (start_opcode),
        .start_acc    (start_acc),
        .start_ve     (start_ve),
        .start_sn     (start_sn),
        .cmd_ff       (cmd_ff),
        .split_busy   (split_busy),
        .cmd_wr       (cmd_wr),
        .cmd_wdata    (cmd_wdata)
    );

    bd_ram u_bd_ram (
        .clk_sys   (clk_sys),
        .ram_wr    (ram_wr),
        .ram_waddr (ram_waddr),
        .ram_wrec  (ram_wrec),
        .ram_raddr (ram_raddr),
        .ram_rrec  (ram_rrec)
    );

    // ----------------------------------------
    // output side
    bd_dispatch #(
        .RSP_AFULL_THD (RSP_AFULL_THD)
    ) u_bd_dispatch (
        .clk_sys       (clk_sys),
        .rst           (rst),
        .rsp_wr        (rsp_wr),
        .rsp_sn        (rsp_sn),
        .kernel_afull  (kernel_afull),
        .mmu_afull     (mmu_afull),
        .ram_rrec      (ram_rrec),
        .rsp_rd        (rsp_rd),
        .rsp_afull     (rsp_afull),
        .ram_raddr     (ram_raddr),
        .kernel_bd_wen (kernel_bd_wen),
        .mmu_bd_wen    (mmu_bd_wen),
        .bd_wdata      (bd_wdata)
    );

endmodule

// ==== testbench/tb_clk_gen.sv ====
`timescale 1ns/1ps

module tb_clk_gen (
    output logic clk_sys,
    output logic rst
);

    // 4 ns period
    initial begin
        clk_sys = 1'b0;
        forever #2 clk_sys = ~clk_sys;
    end

    initial begin
        rst = 1'b1;
        repeat (10) @(posedge clk_sys);
        rst <= 1'b0;
    end

endmodule

// ==== testbench/tx_bd_sva.sv ====
`timescale 1ns/1ps

module tx_bd_sva (
    input logic clk_sys,
    input logic rst,
    input logic bd_rd,
    input logic cmd_wr,
    input logic cmd_ff,
    input logic kernel_bd_wen,
    input logic mmu_bd_wen
);

    // one destination per output word
    wen_exclusive: assert property (@(posedge clk_sys) disable iff (rst)
        !(kernel_bd_wen && mmu_bd_wen))
        else $error("kernel_bd_wen and mmu_bd_wen high in the same cycle");

    pop_spacing: assert property (@(posedge clk_sys) disable iff (rst)
        bd_rd |=> !bd_rd)
        else $error("bd_rd high in two consecutive cycles");

    // command FIFO full blocks the next write
    cmd_backpressure: assert property (@(posedge clk_sys) disable iff (rst)
        cmd_ff |=> !cmd_wr)
        else $error("cmd_wr in the cycle after cmd_ff was high");

endmodule

// ==== testbench/tb_tx_bd.sv ====
`timescale 1ns/1ps

module tb_tx_bd;
    import tx_bd_pkg::*;

    localparam int N_DESC = 8;
    localparam int CHUNK  = 4096;
    localparam int HOLD   = 5;
    localparam int LIMIT  = 20000;

    typedef struct packed {
        logic [31:0] len;
        logic [1:0]  opc;
        logic [7:0]  tid;
        logic [7:0]  acc;
        logic [47:0] ve;
        logic [63:0] src;
        logic [63:0] dst;
        logic [7:0]  ncmd;
    } desc_t;

    // last column is the expected number of read commands
    desc_t desc_tab [N_DESC] = '{
        '{32'd0,     2'd0, 8'h10, 8'ha0, 48'h1111_2222_3333, 64'h1_0000_0f00,
          64'h2_0000_0000, 8'd1},
        '{32'd4096,  2'd1, 8'h21, 8'ha1, 48'h4444_5555_6666, 64'h1_0001_0000,
          64'h2_0001_0040, 8'd1},
        '{32'd4097,  2'd2, 8'h32, 8'ha2, 48'h7777_8888_9999, 64'h1_0002_0010,
          64'h2_0002_0000, 8'd2},
        '{32'd12293, 2'd3, 8'h43, 8'ha3, 48'haaaa_bbbb_cccc, 64'h1_0003_0800,
          64'h2_0003_0100, 8'd4},
        '{32'd100,   2'd1, 8'h54, 8'ha4, 48'hdddd_eeee_ffff, 64'h1_0004_0004,
          64'h2_0004_0000, 8'd1},
        '{32'd8192,  2'd0, 8'h65, 8'ha5, 48'h0123_4567_89ab, 64'h1_0005_0000,
          64'h2_0005_0200, 8'd2},
        '{32'd1,     2'd3, 8'h76, 8'ha6, 48'hcdef_0123_4567, 64'h1_0006_0fff,
          64'h2_0006_0000, 8'd1},
        '{32'd20000, 2'd2, 8'h87, 8'ha7, 48'h89ab_cdef_0123, 64'hf_ffff_f000,
          64'h2_0007_0080, 8'd5}
    };

    logic             clk_sys;
    logic             rst;
    logic [BD_W-1:0]  bd_rdata;
    logic             bd_empty;
    logic             bd_rd;
    logic             cmd_ff;
    logic             cmd_wr;
    logic [CMD_W-1:0] cmd_wdata;
    logic             rsp_wr;
    logic [SN_W-1:0]  rsp_sn;
    logic             kernel_afull;
    logic             mmu_afull;
    logic             kernel_bd_wen;
    logic             mmu_bd_wen;
    logic [OUT_W-1:0] bd_wdata;

    logic [31:0] lfsr;
    int          cyc;
    int          bd_idx;
    logic        pop_pend;
    int          cmd_desc;
    int          cmd_i;
    int          stall_pulses;
    int          pend_q [$];
    int          out_q [$];

    tb_clk_gen u_clk_gen (
        .clk_sys (clk_sys),
        .rst     (rst)
    );

    tx_bd #(
        .BD_INFLIGHT_MAX (450),
        .RSP_AFULL_THD   (450),
        .CHUNK_SHIFT     (12)
    ) UUT (
        .clk_sys       (clk_sys),
        .rst           (rst),
        .bd_rdata      (bd_rdata),
        .bd_empty      (bd_empty),
        .bd_rd         (bd_rd),
        .cmd_ff        (cmd_ff),
        .cmd_wr        (cmd_wr),
        .cmd_wdata     (cmd_wdata),
        .rsp_wr        (rsp_wr),
        .rsp_sn        (rsp_sn),
        .kernel_afull  (kernel_afull),
        .mmu_afull     (mmu_afull),
        .kernel_bd_wen (kernel_bd_wen),
        .mmu_bd_wen    (mmu_bd_wen),
        .bd_wdata      (bd_wdata)
    );

    bind tx_bd tx_bd_sva u_tx_bd_sva (
        .clk_sys       (clk_sys),
        .rst           (rst),
        .bd_rd         (bd_rd),
        .cmd_wr        (cmd_wr),
        .cmd_ff        (cmd_ff),
        .kernel_bd_wen (kernel_bd_wen),
        .mmu_bd_wen    (mmu_bd_wen)
    );

    // galois lfsr stepped once per bit taken
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], lfsr[0]};
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'ha300_0000) : (lfsr >> 1);
        end
        return v;
    endfunction

    // byte order reversed within each 128-bit lane
    function automatic logic [255:0] lane_flip(input logic [255:0] d);
        logic [127:0] hi;
        logic [127:0] lo;
        hi = {<<8{d[255:128]}};
        lo = {<<8{d[127:0]}};
        return {hi, lo};
    endfunction

    function automatic logic [511:0] byte_flip(input logic [511:0] d);
        logic [511:0] r;
        r = {<<8{d}};
        return r;
    endfunction

    function automatic logic [BD_W-1:0] make_bd(input int d);
        logic [255:0] f;
        f = '0;
        f[IN_TID_LSB +: TID_W]  = desc_tab[d].tid;
        f[IN_OPC_LSB +: OPC_W]  = desc_tab[d].opc;
        f[IN_ACC_LSB +: ACC_W]  = desc_tab[d].acc;
        f[IN_VE_LSB +: VE_W]    = desc_tab[d].ve;
        f[IN_LEN_LSB +: LEN_W]  = desc_tab[d].len;
        f[IN_DST_LSB +: ADDR_W] = desc_tab[d].dst;
        f[IN_SRC_LSB +: ADDR_W] = desc_tab[d].src;
        return {32'h0, lane_flip(f)};
    endfunction

    function automatic logic all_done();
        return (cmd_desc == N_DESC) && (pend_q.size() == 0) && (out_q.size() == 0);
    endfunction

    task automatic stop_fail(input string why);
        $display("%s", why);
        $display("FAIL: see errors above");
        $fatal(1);
    endtask

    task automatic check_val(input string name, input logic [511:0] got,
                             input logic [511:0] exp);
        assert (got === exp)
            else stop_fail($sformatf("[FAIL] t=%0t %s: expected %0h, got %0h",
                                     $time, name, exp, got));
    endtask

    task automatic step_cycle();
        int           d;
        int           k;
        int           n;
        logic [31:0]  exp_len;
        logic [255:0] exp_cmd;
        logic [511:0] exp_out;
        logic [1:0]   opc;
        @(negedge clk_sys);
        cyc++;
        if (cyc <= HOLD) begin
            assert (!bd_rd && !cmd_wr && !kernel_bd_wen && !mmu_bd_wen)
                else stop_fail("an output went high before any descriptor was offered");
        end

        // ----------------------------------------
        // descriptor FIFO pops at the edge after bd_rd
        if (pop_pend) begin
            bd_idx++;
        end
        assert (!bd_rd || bd_idx < N_DESC)
            else stop_fail("bd_rd while the descriptor FIFO was empty");
        pop_pend = bd_rd;

        // commands in order with one chunk each
        assert (!cmd_wr || !cmd_ff)
            else stop_fail("cmd_wr came in the cycle after cmd_ff was high");
        if (cmd_wr) begin
            d = cmd_desc;
            assert (d < N_DESC) else stop_fail("cmd_wr with no descriptor outstanding");
            n = int'(desc_tab[d].ncmd);
            if (cmd_i == n - 1) begin
                exp_len = desc_tab[d].len - 32'(CHUNK * (n - 1));
            end else begin
                exp_len = 32'(CHUNK);
            end
            exp_cmd = '0;
            exp_cmd[CMD_SOD_BIT]              = (cmd_i == 0);
            exp_cmd[CMD_EOD_BIT]              = (cmd_i == n - 1);
            exp_cmd[CMD_LEN_LSB +: RD_LEN_W]  = exp_len[RD_LEN_W-1:0];
            exp_cmd[CMD_OPC_LSB +: OPC_W]     = desc_tab[d].opc;
            exp_cmd[CMD_SN_LSB +: SN_W]       = SN_W'(d);
            exp_cmd[CMD_ACC_LSB +: ACC_W]     = desc_tab[d].acc;
            exp_cmd[CMD_VE_LSB +: VE_W]       = desc_tab[d].ve;
            exp_cmd[CMD_LEN2_LSB +: RD_LEN_W] = exp_len[RD_LEN_W-1:0];
            exp_cmd[CMD_SRC_LSB +: ADDR_W]    = desc_tab[d].src + 64'(cmd_i) * 64'(CHUNK);
            check_val("cmd_wdata", 512'(lane_flip(cmd_wdata)), 512'(exp_cmd));
            cmd_i++;
            if (cmd_i == n) begin
                pend_q.push_back(d);
                cmd_desc++;
                cmd_i = 0;
            end
        end

        // ----------------------------------------
        // output words match the return order
        if (kernel_bd_wen || mmu_bd_wen) begin
            assert (out_q.size() > 0)
                else stop_fail("output pulse without a returned serial number");
            d = out_q.pop_front();
            opc = desc_tab[d].opc;
            exp_out = '0;
            exp_out[OUT_SRC_LSB +: ADDR_W] = desc_tab[d].src;
            exp_out[OUT_DST_LSB +: ADDR_W] = desc_tab[d].dst;
            exp_out[OUT_VE_LSB +: VE_W]    = desc_tab[d].ve;
            exp_out[OUT_OPC_LSB +: OPC_W]  = opc;
            exp_out[OUT_TID_LSB +: TID_W]  = desc_tab[d].tid;
            exp_out[OUT_LEN_LSB +: LEN_W]  = desc_tab[d].len;
            check_val("bd_wdata", byte_flip(bd_wdata), exp_out);
            check_val("kernel_bd_wen", 512'(kernel_bd_wen), 512'(opc == 2'd0 || opc == 2'd3));
            check_val("mmu_bd_wen", 512'(mmu_bd_wen), 512'(opc == 2'd1 || opc == 2'd2));
            if (kernel_afull || mmu_afull) begin
                stall_pulses++;
            end
        end
        if (!kernel_afull && !mmu_afull) begin
            stall_pulses = 0;
        end
        assert (stall_pulses <= 2)
            else stop_fail("outputs kept coming more than two pulses into a stall");

        // ----------------------------------------
        // next inputs
        bd_empty = (cyc < HOLD) || (bd_idx >= N_DESC);
        if (bd_idx < N_DESC) begin
            bd_rdata = make_bd(bd_idx);
        end else begin
            bd_rdata = '0;
        end
        cmd_ff = (rand_bits(2) == 32'd3);
        if (rand_bits(3) == 32'd0) begin
            kernel_afull = !kernel_afull;
        end
        if (rand_bits(3) == 32'd0) begin
            mmu_afull = !mmu_afull;
        end
        // a few finished descriptors pile up and return in random order
        rsp_wr = 1'b0;
        if (pend_q.size() >= 3 || (cmd_desc == N_DESC && pend_q.size() > 0)) begin
            if (rand_bits(1) == 32'd1) begin
                k = int'(rand_bits(4)) % pend_q.size();
                d = pend_q[k];
                pend_q.delete(k);
                rsp_wr = 1'b1;
                rsp_sn = SN_W'(d);
                out_q.push_back(d);
            end
        end
    endtask

    initial begin
        bd_rdata     = '0;
        bd_empty     = 1'b1;
        cmd_ff       = 1'b0;
        rsp_wr       = 1'b0;
        rsp_sn       = '0;
        kernel_afull = 1'b0;
        mmu_afull    = 1'b0;
        lfsr         = 32'hbb6d074a;
        cyc          = 0;
        bd_idx       = 0;
        pop_pend     = 1'b0;
        cmd_desc     = 0;
        cmd_i        = 0;
        stall_pulses = 0;

        while (rst !== 1'b0) begin
            @(negedge clk_sys);
            cyc++;
            if (cyc > 100) begin
                stop_fail("reset was never released");
            end
        end
        cyc = 0;

        while (!all_done() && cyc < LIMIT) begin
            step_cycle();
        end
        if (all_done()) begin
            // quiet window where nothing more may come out
            repeat (20) step_cycle();
            $display("PASS: all tests");
            $finish;
        end else begin
            stop_fail("timeout waiting for all commands and output words");
        end
    end

endmodule

// ==== all.f ====
logic/tx_bd_pkg.sv
logic/bd_ram.sv
logic/rsp_fifo.sv
logic/bd_fetch.sv
logic/rd_cmd_split.sv
logic/bd_dispatch.sv
logic/tx_bd.sv
testbench/tb_clk_gen.sv
testbench/tx_bd_sva.sv
testbench/tb_tx_bd.sv

// ==== Makefile ====
SRCS := $(shell cat all.f)

obj_dir/Vtb_tx_bd: all.f $(SRCS)
	verilator --binary --timing --assert -Wno-fatal --top-module tb_tx_bd -f all.f

run: obj_dir/Vtb_tx_bd
	./obj_dir/Vtb_tx_bd

clean:
	rm -rf obj_dir

.PHONY: run clean
